//--- src/rx_dma_pkg.sv
// stream widths, buffer depth, timer constants and framer state encoding
package rx_dma_pkg;

    // stream and field widths
    localparam int word_w = 64;
    localparam int iq_w = 16;
    localparam int tsf_w = 64;
    localparam int len_w = 16;
    localparam int nword_w = 14;
    localparam int rssi_w = 11;
    localparam int gpio_w = 8;

    // output word buffer, depth must stay a power of two
    localparam int buf_depth = 16;
    localparam int buf_aw = 4;

    // 25 clocks per microsecond at 25 MHz
    localparam logic [4:0] clk_per_us = 5'd25;

    // interrupt delay unit in clocks
    localparam logic [1:0] count_scale = 2'd2;

    // stream reset hold length in clocks
    localparam logic [3:0] rst_hold = 4'd8;

    // framer states
    typedef enum logic [2:0] {
        wait_pkt    = 3'b000,
        hdr0        = 3'b001,
        hdr1        = 3'b010,
        wait_filter = 3'b011,
        wait_tlast  = 3'b100,
        wait_rst    = 3'b101
    } framer_state_t;

endpackage

//--- src/rx_stream_if.sv
// framer to stream output link with framer and sink modports
`timescale 1ns/1ps

interface rx_stream_if;

    // buffered word strobe, no handshake
    logic [rx_dma_pkg::word_w-1:0]  word;
    logic                           word_valid;

    // frame control
    logic                           start;
    logic [rx_dma_pkg::nword_w-1:0] num_words;
    logic                           stream_rst;

    // final word left the output
    logic                           tlast_seen;

    modport framer (
        output word, word_valid, start, num_words, stream_rst,
        input  tlast_seen
    );

    modport sink (
        input  word, word_valid, start, num_words, stream_rst,
        output tlast_seen
    );

endinterface

//--- src/rx_tsf_timer.sv
// rx_tsf_timer: microsecond tick, timestamp counter and timestamp lock
`timescale 1ns/1ps

module rx_tsf_timer (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic                         sig_valid,
    output logic                         tick_1us,
    output logic [rx_dma_pkg::tsf_w-1:0] tsf_now,
    output logic [rx_dma_pkg::tsf_w-1:0] tsf_locked
);

    logic [4:0] div_cnt;

    // last cycle of each microsecond
    assign tick_1us = (div_cnt == rx_dma_pkg::clk_per_us - 5'd1);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            div_cnt <= '0;
            tsf_now <= '0;
        end else begin
            if (tick_1us) begin
                div_cnt <= '0;
                tsf_now <= tsf_now + 1'b1;
            end else begin
                div_cnt <= div_cnt + 5'd1;
            end
        end
    end

    // header0 value, taken at the signal field
    always_ff @(posedge clk) begin
        if (sig_valid) begin
            tsf_locked <= tsf_now;
        end
    end

endmodule

//--- src/rx_dma_framer.sv
// rx_dma_framer: header insertion, filter wait, tlast wait and stream reset recovery
`timescale 1ns/1ps

module rx_dma_framer (
    input  logic                           clk,
    input  logic                           rstn,
    input  logic                           sig_valid,
    input  logic                           ht_unsupport,
    input  logic                           ht_sgi,
    input  logic [7:0]                     pkt_rate,
    input  logic [rx_dma_pkg::len_w-1:0]   pkt_len,
    input  logic [rx_dma_pkg::rssi_w-1:0]  rssi_half_db,
    input  logic [rx_dma_pkg::gpio_w-1:0]  gpio_status,
    input  logic [rx_dma_pkg::tsf_w-1:0]   tsf_locked,
    input  logic [rx_dma_pkg::word_w-1:0]  data_from_acc,
    input  logic                           data_ready_from_acc,
    input  logic                           block_valid,
    input  logic                           block,
    input  logic                           tick_1us,
    input  logic                           recover_enable,
    input  logic [12:0]                    recover_timeout_top,
    output logic                           tlast_auto_recover,
    output logic [rx_dma_pkg::nword_w-1:0] num_dma_words,
    rx_stream_if.framer                    strm
);

    rx_dma_pkg::framer_state_t state;

    logic [rx_dma_pkg::word_w-1:0]  hdr1_word;
    logic [rx_dma_pkg::nword_w-1:0] len_words;
    logic [12:0]                    timer_us;
    logic [3:0]                     rst_cnt;
    logic                           accept;
    logic                           timeout;

    assign accept = sig_valid && !ht_unsupport;
    assign timeout = recover_enable && (timer_us > recover_timeout_top);

    // 8-byte words rounded up, plus the two header words
    assign len_words = {1'b0, pkt_len[rx_dma_pkg::len_w-1:3]}
                     + {{(rx_dma_pkg::nword_w-1){1'b0}}, |pkt_len[2:0]}
                     + {{(rx_dma_pkg::nword_w-2){1'b0}}, 2'd2};

    assign num_dma_words = strm.num_words;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= rx_dma_pkg::wait_pkt;
            strm.word_valid <= 1'b0;
            strm.start <= 1'b0;
            strm.stream_rst <= 1'b0;
            strm.num_words <= '0;
            tlast_auto_recover <= 1'b0;
            timer_us <= '0;
            rst_cnt <= '0;
        end else begin
            strm.word_valid <= 1'b0;
            strm.start <= 1'b0;
            tlast_auto_recover <= 1'b0;
            case (state)
                rx_dma_pkg::wait_pkt: begin
                    timer_us <= '0;
                    rst_cnt <= '0;
                    if (accept) begin
                        strm.num_words <= len_words;
                        state <= rx_dma_pkg::hdr0;
                    end
                end
                rx_dma_pkg::hdr0: begin
                    strm.word_valid <= 1'b1;
                    state <= rx_dma_pkg::hdr1;
                end
                rx_dma_pkg::hdr1: begin
                    strm.word_valid <= 1'b1;
                    state <= rx_dma_pkg::wait_filter;
                end
                rx_dma_pkg::wait_filter: begin
                    strm.word_valid <= data_ready_from_acc;
                    if (timeout) begin
                        strm.stream_rst <= 1'b1;
                        tlast_auto_recover <= 1'b1;
                        state <= rx_dma_pkg::wait_rst;
                    end else if (block_valid && !block) begin
                        strm.start <= 1'b1;
                        timer_us <= '0;
                        state <= rx_dma_pkg::wait_tlast;
                    end else if (block_valid && block) begin
                        strm.stream_rst <= 1'b1;
                        state <= rx_dma_pkg::wait_rst;
                    end else if (tick_1us && timer_us != '1) begin
                        timer_us <= timer_us + 13'd1;
                    end
                end
                rx_dma_pkg::wait_tlast: begin
                    strm.word_valid <= data_ready_from_acc;
                    if (timeout) begin
                        strm.stream_rst <= 1'b1;
                        tlast_auto_recover <= 1'b1;
                        state <= rx_dma_pkg::wait_rst;
                    end else begin
                        if (tick_1us && timer_us != '1) begin
                            timer_us <= timer_us + 13'd1;
                        end
                        if (strm.tlast_seen) begin
                            state <= rx_dma_pkg::wait_pkt;
                        end
                    end
                end
                rx_dma_pkg::wait_rst: begin
                    rst_cnt <= rst_cnt + 4'd1;
                    strm.num_words <= '0;
                    if (rst_cnt == rx_dma_pkg::rst_hold - 4'd1) begin
                        strm.stream_rst <= 1'b0;
                        state <= rx_dma_pkg::wait_pkt;
                    end
                end
                default: begin
                    state <= rx_dma_pkg::wait_pkt;
                end
            endcase
        end
    end

    // word mux: timestamp, rate/len/rf word, then decoder payload
    always_ff @(posedge clk) begin
        if (state == rx_dma_pkg::wait_pkt && accept) begin
            // byte 1 above gpio flags a packet present in the host buffer
            hdr1_word <= {10'd0, ht_sgi, pkt_rate[7], pkt_rate[3:0], pkt_len,
                          8'd1, gpio_status, 5'd0, rssi_half_db};
        end
        case (state)
            rx_dma_pkg::hdr0: strm.word <= tsf_locked;
            rx_dma_pkg::hdr1: strm.word <= hdr1_word;
            default:          strm.word <= data_from_acc;
        endcase
    end

    // grant pulse only comes out of the filter wait
    a_start_from_filter: assert property (@(posedge clk) disable iff (!rstn)
        $rose(strm.start) |-> $past(state) == rx_dma_pkg::wait_filter);

    a_rst_hold_len: assert property (@(posedge clk) disable iff (!rstn)
        $rose(strm.stream_rst) |-> strm.stream_rst[*rx_dma_pkg::rst_hold] ##1 !strm.stream_rst);

endmodule

//--- src/rx_stream_out.sv
// rx_stream_out: word buffer, source select, drain under back-pressure and tlast
`timescale 1ns/1ps

module rx_stream_out (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic                            raw_mode,
    input  logic [4*rx_dma_pkg::iq_w-1:0]   rf_iq,
    input  logic                            rf_iq_valid,
    input  logic                            start_ext_trigger,
    input  logic [rx_dma_pkg::nword_w-1:0]  raw_num_words,
    input  logic                            m_axis_tready,
    output logic [rx_dma_pkg::word_w-1:0]   m_axis_tdata,
    output logic                            m_axis_tvalid,
    output logic                            m_axis_tlast,
    output logic                            buf_overflow,
    rx_stream_if.sink                       strm
);

    logic [rx_dma_pkg::word_w-1:0]  mem [rx_dma_pkg::buf_depth];
    logic [rx_dma_pkg::buf_aw:0]    wr_ptr;
    logic [rx_dma_pkg::buf_aw:0]    rd_ptr;
    logic [rx_dma_pkg::buf_aw:0]    fill;
    // words handed to the output register in this frame
    logic [rx_dma_pkg::nword_w-1:0] load_cnt;
    logic [rx_dma_pkg::nword_w-1:0] load_next;
    logic [rx_dma_pkg::nword_w-1:0] target;
    logic [rx_dma_pkg::word_w-1:0]  in_word;
    logic                           in_valid;
    logic                           trigger;
    logic                           running;
    logic                           full;
    logic                           empty;
    logic                           can_load;

    assign in_word  = raw_mode ? rf_iq : strm.word;
    assign in_valid = raw_mode ? rf_iq_valid : strm.word_valid;
    assign trigger  = raw_mode ? start_ext_trigger : strm.start;
    assign target   = raw_mode ? raw_num_words : strm.num_words;

    assign fill  = wr_ptr - rd_ptr;
    assign full  = fill[rx_dma_pkg::buf_aw];
    assign empty = (wr_ptr == rd_ptr);
    assign load_next = load_cnt + 1'b1;
    assign can_load = running && !empty && (load_cnt != target)
                    && (!m_axis_tvalid || m_axis_tready);

    assign strm.tlast_seen = m_axis_tvalid && m_axis_tready && m_axis_tlast;

    always_ff @(posedge clk) begin
        if (!rstn || strm.stream_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            load_cnt <= '0;
            running <= 1'b0;
            m_axis_tvalid <= 1'b0;
            m_axis_tlast <= 1'b0;
            buf_overflow <= 1'b0;
        end else begin
            if (in_valid) begin
                // full buffer drops the incoming word
                if (full) begin
                    buf_overflow <= 1'b1;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (trigger) begin
                running <= 1'b1;
            end
            if (can_load) begin
                rd_ptr <= rd_ptr + 1'b1;
                load_cnt <= load_next;
                m_axis_tvalid <= 1'b1;
                m_axis_tlast <= (load_next == target);
            end else if (m_axis_tready) begin
                m_axis_tvalid <= 1'b0;
                m_axis_tlast <= 1'b0;
            end
            if (strm.tlast_seen) begin
                running <= 1'b0;
                load_cnt <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && !full) begin
            mem[wr_ptr[rx_dma_pkg::buf_aw-1:0]] <= in_word;
        end
        if (can_load) begin
            m_axis_tdata <= mem[rd_ptr[rx_dma_pkg::buf_aw-1:0]];
        end
    end

    a_hold_data: assert property (@(posedge clk) disable iff (!rstn)
        m_axis_tvalid && !m_axis_tready |=> $stable(m_axis_tdata));

endmodule

//--- src/rx_intr_delay.sv
// rx_intr_delay: delayed receive interrupt pulse after the dma completion edge
`timescale 1ns/1ps

module rx_intr_delay (
    input  logic        clk,
    input  logic        rstn,
    input  logic        s2mm_intr,
    input  logic [14:0] count_top,
    output logic        rx_pkt_intr
);

    logic        s2mm_d;
    logic        edge_seen;
    logic        active;
    logic [15:0] count_scaled;
    logic [15:0] count;

    assign edge_seen = s2mm_intr && !s2mm_d;

    // delay setting in clocks
    always_ff @(posedge clk) begin
        count_scaled <= {1'b0, count_top} * rx_dma_pkg::count_scale;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            s2mm_d <= 1'b0;
            active <= 1'b0;
            count <= '0;
            rx_pkt_intr <= 1'b0;
        end else begin
            s2mm_d <= s2mm_intr;
            rx_pkt_intr <= 1'b0;
            if (edge_seen) begin
                // restart on every new edge
                count <= '0;
                active <= 1'b1;
            end else if (active) begin
                if (count == count_scaled) begin
                    rx_pkt_intr <= 1'b1;
                    active <= 1'b0;
                end else begin
                    count <= count + 16'd1;
                end
            end
        end
    end

endmodule

//--- src/rx_intf_top.sv
// rx_intf_top: timestamp timer, dma framer, stream output and interrupt delay
`timescale 1ns/1ps

module rx_intf_top (
    input  logic                            clk,
    input  logic                            rstn,
    // decoder
    input  logic [rx_dma_pkg::word_w-1:0]   data_from_acc,
    input  logic                            data_ready_from_acc,
    input  logic                            sig_valid,
    input  logic                            ht_unsupport,
    input  logic                            ht_sgi,
    input  logic [7:0]                      pkt_rate,
    input  logic [rx_dma_pkg::len_w-1:0]    pkt_len,
    input  logic [rx_dma_pkg::rssi_w-1:0]   rssi_half_db,
    input  logic [rx_dma_pkg::gpio_w-1:0]   gpio_status,
    // filter
    input  logic                            block_valid,
    input  logic                            block,
    // raw path
    input  logic [4*rx_dma_pkg::iq_w-1:0]   rf_iq,
    input  logic                            rf_iq_valid,
    input  logic                            raw_mode,
    input  logic                            start_ext_trigger,
    input  logic [rx_dma_pkg::nword_w-1:0]  raw_num_words,
    // recovery and interrupt settings
    input  logic                            recover_enable,
    input  logic [12:0]                     recover_timeout_top,
    input  logic [14:0]                     count_top,
    input  logic                            s2mm_intr,
    // dma stream
    output logic [rx_dma_pkg::word_w-1:0]   m_axis_tdata,
    output logic                            m_axis_tvalid,
    input  logic                            m_axis_tready,
    output logic                            m_axis_tlast,
    // status
    output logic                            rx_pkt_intr,
    output logic                            tlast_auto_recover,
    output logic [rx_dma_pkg::nword_w-1:0]  num_dma_words,
    output logic                            buf_overflow,
    output logic [rx_dma_pkg::tsf_w-1:0]    tsf_now
);

    logic                         tick_1us;
    logic [rx_dma_pkg::tsf_w-1:0] tsf_locked;

    rx_stream_if strm ();

    rx_tsf_timer u_tsf (
        .clk        (clk),
        .rstn       (rstn),
        .sig_valid  (sig_valid),
        .tick_1us   (tick_1us),
        .tsf_now    (tsf_now),
        .tsf_locked (tsf_locked)
    );

    rx_dma_framer u_framer (
        .clk                 (clk),
        .rstn                (rstn),
        .sig_valid           (sig_valid),
        .ht_unsupport        (ht_unsupport),
        .ht_sgi              (ht_sgi),
        .pkt_rate            (pkt_rate),
        .pkt_len             (pkt_len),
        .rssi_half_db        (rssi_half_db),
        .gpio_status         (gpio_status),
        .tsf_locked          (tsf_locked),
        .data_from_acc       (data_from_acc),
        .data_ready_from_acc (data_ready_from_acc),
        .block_valid         (block_valid),
        .block               (block),
        .tick_1us            (tick_1us),
        .recover_enable      (recover_enable),
        .recover_timeout_top (recover_timeout_top),
        .tlast_auto_recover  (tlast_auto_recover),
        .num_dma_words       (num_dma_words),
        .strm                (strm)
    );

    rx_stream_out u_out (
        .clk               (clk),
        .rstn              (rstn),
        .raw_mode          (raw_mode),
        .rf_iq             (rf_iq),
        .rf_iq_valid       (rf_iq_valid),
        .start_ext_trigger (start_ext_trigger),
        .raw_num_words     (raw_num_words),
        .m_axis_tready     (m_axis_tready),
        .m_axis_tdata      (m_axis_tdata),
        .m_axis_tvalid     (m_axis_tvalid),
        .m_axis_tlast      (m_axis_tlast),
        .buf_overflow      (buf_overflow),
        .strm              (strm)
    );

    rx_intr_delay u_intr (
        .clk         (clk),
        .rstn        (rstn),
        .s2mm_intr   (s2mm_intr),
        .count_top   (count_top),
        .rx_pkt_intr (rx_pkt_intr)
    );

endmodule

//--- test/tb_rx_intf.sv
// directed testbench for rx_intf_top with stream monitor and watchdog
`timescale 1ns/1ps

module tb_rx_intf;

    localparam int clk_per = 4;
    localparam int max_wait = 300;
    // packet flows plus raw, interrupt and timestamp phases
    localparam int phases = 13;

    logic        clk;
    logic        rstn;
    logic [63:0] data_from_acc;
    logic        data_ready_from_acc;
    logic        sig_valid;
    logic        ht_unsupport;
    logic        ht_sgi;
    logic [7:0]  pkt_rate;
    logic [15:0] pkt_len;
    logic [10:0] rssi_half_db;
    logic [7:0]  gpio_status;
    logic        block_valid;
    logic        block;
    logic [63:0] rf_iq;
    logic        rf_iq_valid;
    logic        raw_mode;
    logic        start_ext_trigger;
    logic [13:0] raw_num_words;
    logic        recover_enable;
    logic [12:0] recover_timeout_top;
    logic [14:0] count_top;
    logic        s2mm_intr;
    logic [63:0] m_axis_tdata;
    logic        m_axis_tvalid;
    logic        m_axis_tready;
    logic        m_axis_tlast;
    logic        rx_pkt_intr;
    logic        tlast_auto_recover;
    logic [13:0] num_dma_words;
    logic        buf_overflow;
    logic [63:0] tsf_now;

    integer      seed = 32'h0e4668f7;
    int          err_cnt = 0;
    int          tlast_cnt = 0;
    int          recover_cnt = 0;
    logic [63:0] exp_q[$];
    logic [63:0] got_q[$];
    logic        last_q[$];

    rx_intf_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_per / 2) clk = ~clk;
    end

    initial begin
        #(2 * phases * max_wait * clk_per);
        $display("watchdog expired before the tests completed");
        $display("CHECKS FAILED");
        $fatal(1);
    end

    // stream and recovery monitor
    always @(posedge clk) begin
        if (m_axis_tvalid && m_axis_tready) begin
            got_q.push_back(m_axis_tdata);
            last_q.push_back(m_axis_tlast);
            if (m_axis_tlast) begin
                tlast_cnt++;
            end
        end
        if (tlast_auto_recover) begin
            recover_cnt++;
        end
    end

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] act,
                               input logic [63:0] exp);
        if (act !== exp) begin
            err_cnt++;
            $display("error %s: got %h expected %h", name, act, exp);
            abort_run("value mismatch");
        end
    endtask

    // header1 fields placed at their bit offsets
    function automatic logic [63:0] pack_header1(input logic sgi, input logic [7:0] rate,
                                                 input logic [15:0] len,
                                                 input logic [7:0] gpio,
                                                 input logic [10:0] rssi);
        logic [63:0] w;
        w = 64'd0;
        w[53] = sgi;
        w[52] = rate[7];
        w[51:48] = rate[3:0];
        w[47:32] = len;
        w[31:24] = 8'h01;
        w[23:16] = gpio;
        w[10:0] = rssi;
        return w;
    endfunction

    task automatic clear_queues();
        exp_q.delete();
        got_q.delete();
        last_q.delete();
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
    endtask

    // sig field pulse with random fields and length in bytes
    task automatic start_packet(input bit unsupported, output int len);
        logic [63:0] hdr1;
        len = 1 + ({$random(seed)} % 112);
        @(posedge clk);
        sig_valid <= 1'b1;
        ht_unsupport <= unsupported;
        ht_sgi <= 1'($random(seed));
        pkt_rate <= 8'($random(seed));
        pkt_len <= 16'(len);
        rssi_half_db <= 11'($random(seed));
        gpio_status <= 8'($random(seed));
        @(negedge clk);
        // header0 is the timestamp seen in the sig_valid cycle
        hdr1 = pack_header1(ht_sgi, pkt_rate, pkt_len, gpio_status, rssi_half_db);
        if (!unsupported) begin
            exp_q.push_back(tsf_now);
            exp_q.push_back(hdr1);
        end
        @(posedge clk);
        sig_valid <= 1'b0;
        ht_unsupport <= 1'b0;
        idle(1);
    endtask

    task automatic send_payload(input int n);
        logic [63:0] w;
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            w = {$random(seed), $random(seed)};
            data_from_acc <= w;
            data_ready_from_acc <= 1'b1;
            exp_q.push_back(w);
        end
        @(posedge clk);
        data_ready_from_acc <= 1'b0;
    endtask

    task automatic filter_decision(input bit blk);
        @(posedge clk);
        block_valid <= 1'b1;
        block <= blk;
        @(posedge clk);
        block_valid <= 1'b0;
        block <= 1'b0;
    endtask

    task automatic wait_for_tlast(input bit rand_ready);
        int start_cnt;
        int cyc;
        start_cnt = tlast_cnt;
        cyc = 0;
        while (tlast_cnt == start_cnt) begin
            @(posedge clk);
            m_axis_tready <= rand_ready ? 1'($random(seed)) : 1'b1;
            @(negedge clk);
            cyc++;
            if (cyc > max_wait) begin
                abort_run("tlast was not seen on the stream in time");
            end
        end
        @(posedge clk);
        m_axis_tready <= 1'b1;
    endtask

    task automatic compare_stream();
        check_value("word count", 64'(got_q.size()), 64'(exp_q.size()));
        for (int i = 0; i < exp_q.size(); i++) begin
            check_value("m_axis_tdata", got_q[i], exp_q[i]);
            check_value("m_axis_tlast", 64'(last_q[i]), 64'(i == exp_q.size() - 1));
        end
    endtask

    // timestamp advances by one every microsecond
    task automatic test_tsf_count();
        logic [63:0] t0;
        int cyc;
        t0 = '0;
        cyc = 0;
        @(negedge clk);
        // first pass aligns to an increment and the second one times a full period
        for (int pass = 0; pass < 2; pass++) begin
            t0 = tsf_now;
            cyc = 0;
            while (tsf_now === t0) begin
                @(negedge clk);
                cyc++;
                if (cyc > max_wait) begin
                    abort_run("tsf_now did not advance");
                end
            end
        end
        check_value("tsf_now", tsf_now, t0 + 64'd1);
        check_value("tsf_now period", 64'(cyc), 64'(rx_dma_pkg::clk_per_us));
    endtask

    task automatic run_granted_packet(input bit rand_ready);
        int len;
        int nw;
        clear_queues();
        start_packet(1'b0, len);
        nw = (len + 7) / 8 + 2;
        check_value("num_dma_words", 64'(num_dma_words), 64'(nw));
        send_payload(nw - 2);
        filter_decision(1'b0);
        wait_for_tlast(rand_ready);
        idle(2);
        compare_stream();
    endtask

    task automatic test_granted();
        run_granted_packet(1'b0);
    endtask

    task automatic test_back_pressure();
        run_granted_packet(1'b1);
        run_granted_packet(1'b1);
        check_value("buf_overflow", 64'(buf_overflow), 64'd0);
    endtask

    task automatic test_blocked();
        int len;
        clear_queues();
        start_packet(1'b0, len);
        send_payload((len + 7) / 8);
        filter_decision(1'b1);
        idle(int'(rx_dma_pkg::rst_hold) + 4);
        check_value("blocked word count", 64'(got_q.size()), 64'd0);
        check_value("num_dma_words", 64'(num_dma_words), 64'd0);
        // unsupported ht packets leave the framer idle
        start_packet(1'b1, len);
        idle(6);
        check_value("num_dma_words", 64'(num_dma_words), 64'd0);
        check_value("ignored word count", 64'(got_q.size()), 64'd0);
        run_granted_packet(1'b0);
    endtask

    task automatic test_timeout();
        int len;
        int cyc;
        int lo;
        int hi;
        clear_queues();
        recover_cnt = 0;
        @(posedge clk);
        recover_enable <= 1'b1;
        recover_timeout_top <= 13'd3;
        // fourth tick in wait_filter plus framer and monitor latency
        lo = 3 * int'(rx_dma_pkg::clk_per_us) + 7;
        hi = 4 * int'(rx_dma_pkg::clk_per_us) + 7;
        start_packet(1'b0, len);
        cyc = 3;
        while (recover_cnt == 0) begin
            @(negedge clk);
            cyc++;
            if (cyc > max_wait) begin
                abort_run("tlast_auto_recover never pulsed");
            end
        end
        if (cyc <= lo || cyc > hi) begin
            abort_run("tlast_auto_recover pulsed outside the one tick window");
        end
        idle(2 * int'(rx_dma_pkg::clk_per_us));
        check_value("recover pulse count", 64'(recover_cnt), 64'd1);
        check_value("recovered word count", 64'(got_q.size()), 64'd0);
        recover_enable <= 1'b0;
        idle(2);
        run_granted_packet(1'b0);
    endtask

    task automatic test_raw();
        logic [63:0] w;
        clear_queues();
        @(posedge clk);
        raw_mode <= 1'b1;
        raw_num_words <= 14'd10;
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            w = {$random(seed), $random(seed)};
            rf_iq <= w;
            rf_iq_valid <= 1'b1;
            exp_q.push_back(w);
        end
        @(posedge clk);
        rf_iq_valid <= 1'b0;
        start_ext_trigger <= 1'b1;
        @(posedge clk);
        start_ext_trigger <= 1'b0;
        wait_for_tlast(1'b0);
        idle(2);
        compare_stream();
        // buffer fills without a drain and the extra word is dropped
        @(posedge clk);
        m_axis_tready <= 1'b0;
        for (int i = 0; i <= rx_dma_pkg::buf_depth; i++) begin
            @(posedge clk);
            rf_iq <= {$random(seed), $random(seed)};
            rf_iq_valid <= 1'b1;
        end
        @(posedge clk);
        rf_iq_valid <= 1'b0;
        idle(2);
        check_value("buf_overflow", 64'(buf_overflow), 64'd1);
    endtask

    task automatic test_intr_delay();
        int pulses;
        int at;
        pulses = 0;
        at = -1;
        @(posedge clk);
        count_top <= 15'd5;
        idle(3);
        s2mm_intr <= 1'b1;
        // level stays high for the whole window
        for (int i = 0; i < 60; i++) begin
            @(negedge clk);
            if (rx_pkt_intr) begin
                pulses++;
                at = i;
            end
        end
        check_value("rx_pkt_intr pulses", 64'(pulses), 64'd1);
        check_value("rx_pkt_intr cycle", 64'(at), 64'(5 * int'(rx_dma_pkg::count_scale) + 2));
        @(posedge clk);
        s2mm_intr <= 1'b0;
    endtask

    initial begin
        rstn = 1'b0;
        data_from_acc = '0;
        data_ready_from_acc = 1'b0;
        sig_valid = 1'b0;
        ht_unsupport = 1'b0;
        ht_sgi = 1'b0;
        pkt_rate = '0;
        pkt_len = '0;
        rssi_half_db = '0;
        gpio_status = '0;
        block_valid = 1'b0;
        block = 1'b0;
        rf_iq = '0;
        rf_iq_valid = 1'b0;
        raw_mode = 1'b0;
        start_ext_trigger = 1'b0;
        raw_num_words = '0;
        recover_enable = 1'b0;
        recover_timeout_top = '0;
        count_top = '0;
        s2mm_intr = 1'b0;
        m_axis_tready = 1'b1;
        idle(3);
        rstn <= 1'b1;
        idle(2);
        test_tsf_count();
        test_granted();
        test_back_pressure();
        test_blocked();
        test_timeout();
        test_raw();
        test_intr_delay();
        idle(4);
        if (err_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- sources.f
src/rx_dma_pkg.sv
src/rx_stream_if.sv
src/rx_tsf_timer.sv
src/rx_dma_framer.sv
src/rx_stream_out.sv
src/rx_intr_delay.sv
src/rx_intf_top.sv
test/tb_rx_intf.sv

//--- run_sim.sh
#!/bin/sh
# build and run the rx dma testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_rx_intf -f sources.f -o sim_rx_intf
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/sim_rx_intf 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "ALL CHECKS PASSED"; then
    exit 0
fi
exit 1
